//--- hdl/async_clk_gating.sv
`timescale 1ns/1ps
`default_nettype none

module async_clk_gating (
  input  wire  raw_clk,
  input  wire  active,
  input  wire  bypass,
  input  wire  rst_n,
  output logic gen_clk
);

  // enable as seen by the latch
  logic en_in;
  // latched enable, stable through the high phase
  logic en_lat;

  // test mode opens the gate regardless of enable
  assign en_in = active | bypass;

  // ============================================================
  // low-phase latch
  // ============================================================
  // transparent while raw_clk low, so a change on the enable
  // only shows from the next high phase on, never mid-pulse
  always_latch begin
    if (!rst_n) begin
      en_lat <= 1'b0;
    end else if (!raw_clk) begin
      en_lat <= en_in;
    end
  end

  // gated clock
  assign gen_clk = raw_clk & en_lat;

endmodule

`default_nettype wire

//--- hdl/per_clk_rst_control.sv
`timescale 1ns/1ps
`default_nettype none

module per_clk_rst_control #(
  // bit index into the enable vectors
  parameter int unsigned PER_IDX          = 0,
  // one of DOM_D1, DOM_D2, DOM_D3
  parameter logic [1:0]  DOMAIN           = rcc_pkg::DOM_D1,
  parameter bit          SUPPORT_LPEN     = 1'b0,
  parameter bit          SUPPORT_AMEN     = 1'b0,
  // implicitly owned by cpu1, its enable bit is ignored
  parameter bit          ASSIGNED_TO_CPU1 = 1'b0
) (
  input  wire       bus_clk,
  input  wire       arst_n,
  input  wire       d1_rst_n,
  input  wire       d2_rst_n,
  input  wire       arcg_on,
  input  wire       testmode,
  per_en_if.ctrl    en,
  cpu_pwr_if.ctrl   pwr,
  output logic      per_clk,
  output logic      per_rst_n
);

  logic c1_clk_lpen;
  logic c2_clk_lpen;
  logic c1_clk_en;
  logic c2_clk_en;
  logic d3_clk_en;
  logic arcg_clk_en;
  logic bus_clk_en;

  // ============================================================
  // clock enable
  // ============================================================

  // low-power term, each cpu with its own sleep state
  generate
    if (SUPPORT_LPEN) begin : g_lpen
      assign c1_clk_lpen = ~pwr.c1_sleep | en.c1_lpen[PER_IDX];
      assign c2_clk_lpen = ~pwr.c2_sleep | en.c2_lpen[PER_IDX];
    end else begin : g_no_lpen
      // no lp control, sleep keeps the clock
      assign c1_clk_lpen = 1'b1;
      assign c2_clk_lpen = 1'b1;
    end
  endgenerate

  // cpu1 side, deep sleep always blocks
  generate
    if (ASSIGNED_TO_CPU1) begin : g_cpu1_owned
      assign c1_clk_en = c1_clk_lpen & ~pwr.c1_deepsleep;
    end else begin : g_cpu1_en
      assign c1_clk_en = en.c1_en[PER_IDX] & c1_clk_lpen & ~pwr.c1_deepsleep;
    end
  endgenerate

  // cpu2 side
  assign c2_clk_en = en.c2_en[PER_IDX] & c2_clk_lpen & ~pwr.c2_deepsleep;

  // d3 stop mode
  generate
    if (DOMAIN == rcc_pkg::DOM_D3) begin : g_d3
      if (SUPPORT_AMEN) begin : g_amen
        // autonomous: runs with both cpus down
        assign d3_clk_en = en.amen[PER_IDX] & ~pwr.d3_deepsleep;
      end else begin : g_no_amen
        // clocked until d3 stops
        assign d3_clk_en = ~pwr.d3_deepsleep;
      end
    end else begin : g_d1_d2
      assign d3_clk_en = 1'b0;
    end
  endgenerate

  // hold clock off for a while after reset release
  sync_reset_clk_gate #(
    .DELAY (rcc_pkg::RST_CLK_DELAY)
  ) u_sync_reset_clk_gate (
    .bus_clk   (bus_clk),
    .src_rst_n (per_rst_n),
    .arcg_on   (arcg_on),
    .clk_en    (arcg_clk_en)
  );

  assign bus_clk_en = (c1_clk_en | c2_clk_en | d3_clk_en) & arcg_clk_en;

  // glitch-free gate, testmode forces it open
  async_clk_gating u_bus_clk_gating (
    .raw_clk (bus_clk),
    .active  (bus_clk_en),
    .bypass  (testmode),
    .rst_n   (per_rst_n),
    .gen_clk (per_clk)
  );

  // ============================================================
  // peripheral reset
  // ============================================================
  // combinational, own domain plus sw reset
  generate
    if (DOMAIN == rcc_pkg::DOM_D1) begin : g_rst_d1
      assign per_rst_n = arst_n & d1_rst_n & en.sft_rst_n[PER_IDX];
    end else if (DOMAIN == rcc_pkg::DOM_D2) begin : g_rst_d2
      assign per_rst_n = arst_n & d2_rst_n & en.sft_rst_n[PER_IDX];
    end else begin : g_rst_d3
      // d3 has no domain reset input here
      assign per_rst_n = arst_n & en.sft_rst_n[PER_IDX];
    end
  endgenerate

endmodule

`default_nettype wire

//--- hdl/rcc_if.sv
`timescale 1ns/1ps
`default_nettype none

// enable vectors from the register block to each peripheral control
interface per_en_if;

  // one bit per peripheral
  logic [rcc_pkg::NUM_PER-1:0] c1_en;
  logic [rcc_pkg::NUM_PER-1:0] c1_lpen;
  logic [rcc_pkg::NUM_PER-1:0] c2_en;
  logic [rcc_pkg::NUM_PER-1:0] c2_lpen;
  logic [rcc_pkg::NUM_PER-1:0] amen;
  // active low, already inverted from RSTR
  logic [rcc_pkg::NUM_PER-1:0] sft_rst_n;

  modport regs (
    output c1_en, c1_lpen, c2_en, c2_lpen, amen, sft_rst_n
  );

  // each control picks its own index
  modport ctrl (
    input c1_en, c1_lpen, c2_en, c2_lpen, amen, sft_rst_n
  );

endinterface

// sleep states from the power controller
interface cpu_pwr_if;

  logic c1_sleep;
  logic c1_deepsleep;
  logic c2_sleep;
  logic c2_deepsleep;
  // D3 domain stop mode
  logic d3_deepsleep;

  modport ctrl (
    input c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep, d3_deepsleep
  );

endinterface

`default_nettype wire

//--- hdl/rcc_per_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module rcc_per_subsys (
  input  wire                            bus_clk,
  input  wire                            arst_n,
  input  wire                            d1_rst_n,
  input  wire                            d2_rst_n,
  // register access
  input  wire                            reg_wr,
  input  wire  [rcc_pkg::ADDR_W-1:0]     reg_addr,
  input  wire  [rcc_pkg::DATA_W-1:0]     reg_wdata,
  output wire  [rcc_pkg::DATA_W-1:0]     reg_rdata,
  // power states
  input  wire                            c1_sleep,
  input  wire                            c1_deepsleep,
  input  wire                            c2_sleep,
  input  wire                            c2_deepsleep,
  input  wire                            d3_deepsleep,
  input  wire                            arcg_on,
  input  wire                            testmode,
  // peripheral side
  output wire  [rcc_pkg::NUM_PER-1:0]    per_clk,
  output wire  [rcc_pkg::NUM_PER-1:0]    per_rst_n
);

  per_en_if  en_bus ();
  cpu_pwr_if pwr_bus ();

  // power states onto the shared bundle
  assign pwr_bus.c1_sleep     = c1_sleep;
  assign pwr_bus.c1_deepsleep = c1_deepsleep;
  assign pwr_bus.c2_sleep     = c2_sleep;
  assign pwr_bus.c2_deepsleep = c2_deepsleep;
  assign pwr_bus.d3_deepsleep = d3_deepsleep;

  // ============================================================
  // register block
  // ============================================================
  rcc_regs u_rcc_regs (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .en        (en_bus.regs)
  );

  // ============================================================
  // per-peripheral controls
  // ============================================================
  // peripheral 0, D1 with low-power enables
  per_clk_rst_control #(
    .PER_IDX (0), .DOMAIN (rcc_pkg::DOM_D1), .SUPPORT_LPEN (1'b1),
    .SUPPORT_AMEN (1'b0), .ASSIGNED_TO_CPU1 (1'b0)
  ) u_per0_ctrl (
    .bus_clk (bus_clk), .arst_n (arst_n), .d1_rst_n (d1_rst_n), .d2_rst_n (d2_rst_n),
    .arcg_on (arcg_on), .testmode (testmode), .en (en_bus.ctrl), .pwr (pwr_bus.ctrl),
    .per_clk (per_clk[0]), .per_rst_n (per_rst_n[0])
  );

  // peripheral 1, D2, owned by cpu1
  per_clk_rst_control #(
    .PER_IDX (1), .DOMAIN (rcc_pkg::DOM_D2), .SUPPORT_LPEN (1'b0),
    .SUPPORT_AMEN (1'b0), .ASSIGNED_TO_CPU1 (1'b1)
  ) u_per1_ctrl (
    .bus_clk (bus_clk), .arst_n (arst_n), .d1_rst_n (d1_rst_n), .d2_rst_n (d2_rst_n),
    .arcg_on (arcg_on), .testmode (testmode), .en (en_bus.ctrl), .pwr (pwr_bus.ctrl),
    .per_clk (per_clk[1]), .per_rst_n (per_rst_n[1])
  );

  // peripheral 2, D3 with autonomous mode
  per_clk_rst_control #(
    .PER_IDX (2), .DOMAIN (rcc_pkg::DOM_D3), .SUPPORT_LPEN (1'b0),
    .SUPPORT_AMEN (1'b1), .ASSIGNED_TO_CPU1 (1'b0)
  ) u_per2_ctrl (
    .bus_clk (bus_clk), .arst_n (arst_n), .d1_rst_n (d1_rst_n), .d2_rst_n (d2_rst_n),
    .arcg_on (arcg_on), .testmode (testmode), .en (en_bus.ctrl), .pwr (pwr_bus.ctrl),
    .per_clk (per_clk[2]), .per_rst_n (per_rst_n[2])
  );

endmodule

`default_nettype wire

//--- hdl/rcc_pkg.sv
`default_nettype none

package rcc_pkg;

  // ============================================================
  // sizes
  // ============================================================
  localparam int unsigned NUM_PER = 3;
  localparam int unsigned ADDR_W  = 2;
  localparam int unsigned DATA_W  = 8;

  // low-power enable field offset in C1ENR and C2ENR
  localparam int unsigned LPEN_LSB = 4;

  // ============================================================
  // register map
  // ============================================================
  localparam logic [ADDR_W-1:0] ADDR_C1ENR = 2'd0;
  localparam logic [ADDR_W-1:0] ADDR_C2ENR = 2'd1;
  localparam logic [ADDR_W-1:0] ADDR_AMENR = 2'd2;
  localparam logic [ADDR_W-1:0] ADDR_RSTR  = 2'd3;

  // power domain codes
  localparam logic [1:0] DOM_D1 = 2'd1;
  localparam logic [1:0] DOM_D2 = 2'd2;
  localparam logic [1:0] DOM_D3 = 2'd3;

  // clock-off cycles after peripheral reset release
  localparam int unsigned RST_CLK_DELAY = 2;

endpackage

`default_nettype wire

//--- hdl/rcc_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rcc_regs (
  input  wire                             bus_clk,
  input  wire                             arst_n,
  input  wire                             reg_wr,
  input  wire  [rcc_pkg::ADDR_W-1:0]      reg_addr,
  input  wire  [rcc_pkg::DATA_W-1:0]      reg_wdata,
  output logic [rcc_pkg::DATA_W-1:0]      reg_rdata,
  per_en_if.regs                          en
);

  // cpu1 enable register fields
  logic [rcc_pkg::NUM_PER-1:0] c1_en_q;
  logic [rcc_pkg::NUM_PER-1:0] c1_lpen_q;
  // cpu2 enable register fields
  logic [rcc_pkg::NUM_PER-1:0] c2_en_q;
  logic [rcc_pkg::NUM_PER-1:0] c2_lpen_q;
  // autonomous mode enables
  logic [rcc_pkg::NUM_PER-1:0] amen_q;
  // software reset, 1 holds in reset
  logic [rcc_pkg::NUM_PER-1:0] rst_q;

  // ============================================================
  // register write
  // ============================================================
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      // everything unclocked and out of sw reset
      c1_en_q   <= '0;
      c1_lpen_q <= '0;
      c2_en_q   <= '0;
      c2_lpen_q <= '0;
      amen_q    <= '0;
      rst_q     <= '0;
    end else if (reg_wr) begin
      case (reg_addr)
        rcc_pkg::ADDR_C1ENR: begin
          c1_en_q   <= reg_wdata[rcc_pkg::NUM_PER-1:0];
          c1_lpen_q <= reg_wdata[rcc_pkg::LPEN_LSB +: rcc_pkg::NUM_PER];
        end
        rcc_pkg::ADDR_C2ENR: begin
          c2_en_q   <= reg_wdata[rcc_pkg::NUM_PER-1:0];
          c2_lpen_q <= reg_wdata[rcc_pkg::LPEN_LSB +: rcc_pkg::NUM_PER];
        end
        rcc_pkg::ADDR_AMENR: begin
          amen_q <= reg_wdata[rcc_pkg::NUM_PER-1:0];
        end
        rcc_pkg::ADDR_RSTR: begin
          rst_q <= reg_wdata[rcc_pkg::NUM_PER-1:0];
        end
      endcase
    end
  end

  // ============================================================
  // readback, combinational
  // ============================================================
  always_comb begin
    // undefined bits read as zero
    reg_rdata = '0;
    case (reg_addr)
      rcc_pkg::ADDR_C1ENR: begin
        reg_rdata[rcc_pkg::NUM_PER-1:0]                   = c1_en_q;
        reg_rdata[rcc_pkg::LPEN_LSB +: rcc_pkg::NUM_PER]  = c1_lpen_q;
      end
      rcc_pkg::ADDR_C2ENR: begin
        reg_rdata[rcc_pkg::NUM_PER-1:0]                   = c2_en_q;
        reg_rdata[rcc_pkg::LPEN_LSB +: rcc_pkg::NUM_PER]  = c2_lpen_q;
      end
      rcc_pkg::ADDR_AMENR: begin
        reg_rdata[rcc_pkg::NUM_PER-1:0] = amen_q;
      end
      rcc_pkg::ADDR_RSTR: begin
        reg_rdata[rcc_pkg::NUM_PER-1:0] = rst_q;
      end
    endcase
  end

  // fan out to the controls
  assign en.c1_en   = c1_en_q;
  assign en.c1_lpen = c1_lpen_q;
  assign en.c2_en   = c2_en_q;
  assign en.c2_lpen = c2_lpen_q;
  assign en.amen    = amen_q;
  // active low towards the peripherals
  assign en.sft_rst_n = ~rst_q;

endmodule

`default_nettype wire

//--- hdl/sync_reset_clk_gate.sv
`timescale 1ns/1ps
`default_nettype none

module sync_reset_clk_gate #(
  parameter int unsigned DELAY = rcc_pkg::RST_CLK_DELAY
) (
  input  wire  bus_clk,
  input  wire  src_rst_n,
  input  wire  arcg_on,
  output logic clk_en
);

  // counter wide enough for DELAY, at least one bit
  localparam int unsigned CNT_W = (DELAY < 1) ? 1 : $clog2(DELAY + 1);

  logic [1:0]       sync_q;
  logic [CNT_W-1:0] cnt;
  logic             cnt_done;

  // release synchronizer
  // assert is async, release takes two edges
  always_ff @(posedge bus_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // count DELAY edges once the release is through
  // saturates at DELAY
  always_ff @(posedge bus_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      cnt <= '0;
    end else if (sync_q[1] && !cnt_done) begin
      cnt <= cnt + 1'b1;
    end
  end

  assign cnt_done = (cnt == CNT_W'(DELAY));

  // arcg off: only the reset level matters
  assign clk_en = arcg_on ? (sync_q[1] && cnt_done) : src_rst_n;

endmodule

`default_nettype wire

//--- src.f
hdl/rcc_pkg.sv
hdl/rcc_if.sv
hdl/rcc_regs.sv
hdl/sync_reset_clk_gate.sv
hdl/async_clk_gating.sv
hdl/per_clk_rst_control.sv
hdl/rcc_per_subsys.sv
tb/rcc_checker.sv
tb/tb_rcc_per_subsys.sv

//--- tb/rcc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rcc_checker #(
  // D3 peripherals also need d3 stop mode to lose the clock
  parameter bit IS_D3 = 1'b0
) (
  input wire bus_clk,
  input wire arst_n,
  input wire testmode,
  input wire c1_deepsleep,
  input wire c2_deepsleep,
  input wire d3_deepsleep,
  input wire per_clk,
  input wire per_rst_n
);

  // every domain that can clock this peripheral is stopped
  wire all_deep;

  // count of failed assertions
  int unsigned fail_cnt = 0;

  assign all_deep = c1_deepsleep & c2_deepsleep & (!IS_D3 | d3_deepsleep);

  // ============================================================
  // properties
  // ============================================================
  // no rising edge on the gated clock while the peripheral is held
  a_no_clk_in_reset : assert property (@(posedge per_clk) testmode || per_rst_n)
    else begin
      $error("gated clock pulse while peripheral reset is low");
      fail_cnt++;
    end

  // deep sleep everywhere stops the clock
  a_no_clk_deepsleep : assert property (@(posedge per_clk) testmode || !all_deep)
    else begin
      $error("gated clock pulse with all relevant domains in deep sleep");
      fail_cnt++;
    end

  // global reset reaches the peripheral reset
  a_rst_follows_arst : assert property (@(posedge bus_clk) !arst_n |-> !per_rst_n)
    else begin
      $error("per_rst_n high while arst_n is low");
      fail_cnt++;
    end

endmodule

bind per_clk_rst_control rcc_checker #(
  .IS_D3 (DOMAIN == rcc_pkg::DOM_D3)
) u_rcc_checker (
  .bus_clk      (bus_clk),
  .arst_n       (arst_n),
  .testmode     (testmode),
  .c1_deepsleep (pwr.c1_deepsleep),
  .c2_deepsleep (pwr.c2_deepsleep),
  .d3_deepsleep (pwr.d3_deepsleep),
  .per_clk      (per_clk),
  .per_rst_n    (per_rst_n)
);

`default_nettype wire

//--- tb/tb_rcc_per_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rcc_per_subsys;

  // sum of all test lengths in bus_clk cycles
  localparam int TEST_CYCLES = 104;
  // margin on top
  localparam int CYCLE_LIMIT = TEST_CYCLES + 50;
  // edges with the clock off after a reset release
  localparam int OFF_EDGES   = rcc_pkg::RST_CLK_DELAY + 2;

  logic                         bus_clk;
  logic                         arst_n;
  logic                         d1_rst_n;
  logic                         d2_rst_n;
  logic                         reg_wr;
  logic [rcc_pkg::ADDR_W-1:0]   reg_addr;
  logic [rcc_pkg::DATA_W-1:0]   reg_wdata;
  wire  [rcc_pkg::DATA_W-1:0]   reg_rdata;
  logic                         c1_sleep;
  logic                         c1_deepsleep;
  logic                         c2_sleep;
  logic                         c2_deepsleep;
  logic                         d3_deepsleep;
  logic                         arcg_on;
  logic                         testmode;
  wire  [rcc_pkg::NUM_PER-1:0]  per_clk;
  wire  [rcc_pkg::NUM_PER-1:0]  per_rst_n;

  integer seed = 32'h626e_a6f8;
  int     cycles = 0;

  // failed assertions across the three bound checkers
  wire  [31:0]                  assert_fails;

  rcc_per_subsys uut (
    .bus_clk (bus_clk), .arst_n (arst_n), .d1_rst_n (d1_rst_n), .d2_rst_n (d2_rst_n),
    .reg_wr (reg_wr), .reg_addr (reg_addr), .reg_wdata (reg_wdata), .reg_rdata (reg_rdata),
    .c1_sleep (c1_sleep), .c1_deepsleep (c1_deepsleep), .c2_sleep (c2_sleep),
    .c2_deepsleep (c2_deepsleep), .d3_deepsleep (d3_deepsleep), .arcg_on (arcg_on),
    .testmode (testmode), .per_clk (per_clk), .per_rst_n (per_rst_n)
  );

  assign assert_fails = uut.u_per0_ctrl.u_rcc_checker.fail_cnt
                      + uut.u_per1_ctrl.u_rcc_checker.fail_cnt
                      + uut.u_per2_ctrl.u_rcc_checker.fail_cnt;

  // ============================================================
  // clock and timeout
  // ============================================================
  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $fatal(1);
    end
  end

  // bound assertions, looked at once per cycle
  always @(negedge bus_clk) begin
    check_value("assertion failures", assert_fails, 32'd0);
  end

  // ============================================================
  // helpers
  // ============================================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // one write strobe, register updates on the rising edge in between
  task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge bus_clk);
    reg_wr    = 1'b0;
  endtask

  // address on the falling edge, data looked at a step later
  task automatic read_expect(input logic [1:0] addr, input logic [7:0] exp);
    reg_addr = addr;
    #1;
    check_value($sformatf("reg_rdata[%0d]", addr), reg_rdata, exp);
    @(negedge bus_clk);
  endtask

  // pulses counted mid high phase, each peripheral all or nothing
  task automatic expect_clocks(input int n, input logic [2:0] exp_on);
    int cnt [3];
    cnt = '{0, 0, 0};
    for (int c = 0; c < n; c++) begin
      @(posedge bus_clk);
      #2;
      for (int p = 0; p < 3; p++) begin
        if (per_clk[p] === 1'b1) cnt[p]++;
      end
    end
    for (int p = 0; p < 3; p++) begin
      check_value($sformatf("per_clk[%0d] pulses", p), cnt[p], exp_on[p] ? n : 0);
    end
    @(negedge bus_clk);
  endtask

  // clock held off for OFF_EDGES edges after release, then running
  task automatic expect_release_delay(input int p);
    for (int k = 1; k <= OFF_EDGES + 2; k++) begin
      @(posedge bus_clk);
      #2;
      check_value($sformatf("per_clk[%0d] edge %0d", p, k), per_clk[p], k > OFF_EDGES);
    end
    @(negedge bus_clk);
  endtask

  // ============================================================
  // tests
  // ============================================================
  task automatic reset_and_readback();
    logic [7:0] data;
    logic [7:0] mask;
    arst_n = 1'b0;
    // gated clocks quiet through the reset cycles
    expect_clocks(2, 3'b000);
    check_value("per_rst_n in reset", per_rst_n, 3'b000);
    arst_n = 1'b1;
    #1;
    check_value("per_rst_n after reset", per_rst_n, 3'b111);
    @(negedge bus_clk);
    for (int a = 0; a < 4; a++) read_expect(a[1:0], 8'h00);
    for (int a = 0; a < 4; a++) begin
      data = $random(seed);
      // only enable and lp enable fields exist
      mask = (a < 2) ? 8'h77 : 8'h07;
      @(negedge bus_clk);
      write_reg(a[1:0], data);
      read_expect(a[1:0], data & mask);
    end
    for (int a = 0; a < 4; a++) write_reg(a[1:0], 8'h00);
    repeat (OFF_EDGES + 2) @(negedge bus_clk);
  endtask

  task automatic cpu_enables();
    write_reg(rcc_pkg::ADDR_C1ENR, 8'h01);
    // per1 follows cpu1 regardless of its bit
    expect_clocks(4, 3'b011);
    write_reg(rcc_pkg::ADDR_C1ENR, 8'h00);
    expect_clocks(4, 3'b010);
  endtask

  task automatic low_power_enable();
    write_reg(rcc_pkg::ADDR_C1ENR, 8'h01);
    c1_sleep = 1'b1;
    expect_clocks(4, 3'b010);
    write_reg(rcc_pkg::ADDR_C1ENR, 8'h11);
    expect_clocks(4, 3'b011);
    c1_deepsleep = 1'b1;
    expect_clocks(4, 3'b000);
    write_reg(rcc_pkg::ADDR_C1ENR, 8'h01);
    expect_clocks(4, 3'b000);
    c1_sleep     = 1'b0;
    c1_deepsleep = 1'b0;
    write_reg(rcc_pkg::ADDR_C1ENR, 8'h00);
  endtask

  task automatic d3_autonomous();
    write_reg(rcc_pkg::ADDR_AMENR, 8'h04);
    c1_deepsleep = 1'b1;
    c2_deepsleep = 1'b1;
    expect_clocks(4, 3'b100);
    d3_deepsleep = 1'b1;
    expect_clocks(4, 3'b000);
    d3_deepsleep = 1'b0;
    c1_deepsleep = 1'b0;
    c2_deepsleep = 1'b0;
    write_reg(rcc_pkg::ADDR_AMENR, 8'h00);
  endtask

  task automatic resets_and_delay();
    write_reg(rcc_pkg::ADDR_C1ENR, 8'h01);
    write_reg(rcc_pkg::ADDR_RSTR, 8'h01);
    check_value("per_rst_n sw reset", per_rst_n, 3'b110);
    expect_clocks(3, 3'b010);
    write_reg(rcc_pkg::ADDR_RSTR, 8'h00);
    expect_release_delay(0);
    // D1 reset holds only peripheral 0
    d1_rst_n = 1'b0;
    #1;
    check_value("per_rst_n d1 reset", per_rst_n, 3'b110);
    @(negedge bus_clk);
    d1_rst_n = 1'b1;
    expect_release_delay(0);
    // D2 reset holds only peripheral 1
    d2_rst_n = 1'b0;
    #1;
    check_value("per_rst_n d2 reset", per_rst_n, 3'b101);
    @(negedge bus_clk);
    d2_rst_n = 1'b1;
    expect_release_delay(1);
    write_reg(rcc_pkg::ADDR_C1ENR, 8'h00);
  endtask

  task automatic test_mode_bypass();
    c1_deepsleep = 1'b1;
    c2_deepsleep = 1'b1;
    d3_deepsleep = 1'b1;
    testmode     = 1'b1;
    expect_clocks(4, 3'b111);
    testmode     = 1'b0;
    expect_clocks(4, 3'b000);
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    arst_n       = 1'b0;
    d1_rst_n     = 1'b1;
    d2_rst_n     = 1'b1;
    reg_wr       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    c1_sleep     = 1'b0;
    c1_deepsleep = 1'b0;
    c2_sleep     = 1'b0;
    c2_deepsleep = 1'b0;
    d3_deepsleep = 1'b0;
    arcg_on      = 1'b1;
    testmode     = 1'b0;
    reset_and_readback();
    cpu_enables();
    low_power_enable();
    d3_autonomous();
    resets_and_delay();
    test_mode_bypass();
    check_value("assertion failures", assert_fails, 32'd0);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire
